//--- run_sim.sh
#!/bin/bash
# build the testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir

verilator --binary --timing --assert -f src.f --top-module tb_dcache_wb -o sim_tb \
	&& ./obj_dir/sim_tb | tee /dev/stderr | grep -x "Everything OK" > /dev/null \
	&& echo "simulation passed" \
	|| { echo "simulation FAILED"; exit 1; }

//--- sim/bus_memory_model.sv
`timescale 1ns/1ns

module bus_memory_model #(
	parameter logic [31:0] SEED = 32'h666bcb97
) (
	input  logic i_clock,
	input  logic i_rst_n,
	input  logic i_stall,	// holds off every access while high
	input  logic i_bus_request,
	input  logic i_bus_rw,
	input  wbuf_pkg::addr_t i_bus_address,
	input  wbuf_pkg::data_t i_bus_wdata,
	output logic o_bus_ready,
	output wbuf_pkg::data_t o_bus_rdata
);

	// only written words are stored
	wbuf_pkg::data_t mem [wbuf_pkg::addr_t];

	// every completed write, oldest first
	wbuf_pkg::addr_t log_addr [$];
	wbuf_pkg::data_t log_data [$];

	logic [31:0] rng_state;
	logic [31:0] rng_next;
	logic busy;
	logic [1:0] wait_cnt;	// 0 to 3 wait cycles

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	// untouched words read back as the inverted address
	function automatic wbuf_pkg::data_t fetch(input wbuf_pkg::addr_t a);
		if (mem.exists(a)) begin
			return mem[a];
		end
		return ~a;
	endfunction

	assign rng_next = lcg_next(rng_state);

	always @(posedge i_clock or negedge i_rst_n) begin
		if (!i_rst_n) begin
			o_bus_ready <= 1'b0;
			o_bus_rdata <= '0;
			busy <= 1'b0;
			wait_cnt <= '0;
			rng_state <= SEED;
		end else begin
			o_bus_ready <= 1'b0;	// one cycle per access
			if (i_bus_request && !o_bus_ready && !i_stall) begin
				if (!busy) begin
					busy <= 1'b1;
					wait_cnt <= rng_next[17:16];
					rng_state <= rng_next;
				end else if (wait_cnt != 2'd0) begin
					wait_cnt <= wait_cnt - 2'd1;
				end else begin
					busy <= 1'b0;
					o_bus_ready <= 1'b1;
					o_bus_rdata <= fetch(i_bus_address);
					if (i_bus_rw) begin
						mem[i_bus_address] = i_bus_wdata;
						log_addr.push_back(i_bus_address);
						log_data.push_back(i_bus_wdata);
					end
				end
			end
		end
	end

endmodule

//--- sim/tb_dcache_wb.sv
`timescale 1ns/1ns

module tb_dcache_wb;

	localparam int TIMEOUT = 200;	// cycles per wait

	logic clock;
	logic rst_n;
	logic req_valid;
	logic req_ready;
	logic req_rw;
	wbuf_pkg::addr_t req_addr;
	wbuf_pkg::data_t req_wdata;
	logic rsp_valid;
	wbuf_pkg::data_t rsp_rdata;
	logic rsp_err;
	logic bus_request;
	logic bus_rw;
	wbuf_pkg::addr_t bus_address;
	wbuf_pkg::data_t bus_wdata;
	logic bus_ready;
	wbuf_pkg::data_t bus_rdata;
	logic stall;

	logic [31:0] rng;
	wbuf_pkg::addr_t exp_addr [$];	// writes in issue order
	wbuf_pkg::data_t exp_data [$];
	int bus_starts;
	int starts_before;
	logic bus_req_d;
	wbuf_pkg::data_t wr_data;
	wbuf_pkg::addr_t wr_addr;

	dcache_wb_top UUT (
		.i_clock       (clock),
		.i_rst_n       (rst_n),
		.i_req_valid   (req_valid),
		.o_req_ready   (req_ready),
		.i_req_rw      (req_rw),
		.i_req_addr    (req_addr),
		.i_req_wdata   (req_wdata),
		.o_rsp_valid   (rsp_valid),
		.o_rsp_rdata   (rsp_rdata),
		.o_rsp_err     (rsp_err),
		.o_bus_request (bus_request),
		.o_bus_rw      (bus_rw),
		.o_bus_address (bus_address),
		.o_bus_wdata   (bus_wdata),
		.i_bus_ready   (bus_ready),
		.i_bus_rdata   (bus_rdata)
	);

	bus_memory_model #(.SEED(32'h666bcb97)) memory (
		.i_clock       (clock),
		.i_rst_n       (rst_n),
		.i_stall       (stall),
		.i_bus_request (bus_request),
		.i_bus_rw      (bus_rw),
		.i_bus_address (bus_address),
		.i_bus_wdata   (bus_wdata),
		.o_bus_ready   (bus_ready),
		.o_bus_rdata   (bus_rdata)
	);

	always #2 clock = ~clock;

	// counts bus cycles started by sampling the request on falling edges
	always @(negedge clock) begin
		bus_req_d <= bus_request;
		if (bus_request && !bus_req_d) begin
			bus_starts <= bus_starts + 1;
		end
	end

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	function automatic logic [31:0] next_rand();
		rng = lcg_next(rng);
		return rng;
	endfunction

	task automatic check_value(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		assert (actual === expected) else begin
			$display("[FAIL] %s expected %h actual %h", name, expected, actual);
			$display("Something failed");
			$fatal(1);
		end
	endtask

	task automatic timeout_fail(input string what);
		$display("timeout while waiting for %s", what);
		$display("Something failed");
		$fatal(1);
	endtask

	// present a request and hold it until captured
	task automatic send_request(input logic rw, input wbuf_pkg::addr_t addr,
			input wbuf_pkg::data_t wdata);
		int cycles;
		cycles = 0;
		@(posedge clock);
		req_valid <= 1'b1;
		req_rw <= rw;
		req_addr <= addr;
		req_wdata <= wdata;
		@(negedge clock);
		while (!req_ready) begin
			cycles++;
			if (cycles > TIMEOUT) timeout_fail("o_req_ready");
			@(negedge clock);
		end
		@(posedge clock);
		req_valid <= 1'b0;
		if (rw && addr[1:0] == 2'b00) begin
			exp_addr.push_back(addr);
			exp_data.push_back(wdata);
		end
	endtask

	task automatic wait_response(output wbuf_pkg::data_t data, output logic err);
		int cycles;
		cycles = 0;
		@(negedge clock);
		while (!rsp_valid) begin
			cycles++;
			if (cycles > TIMEOUT) timeout_fail("o_rsp_valid");
			@(negedge clock);
		end
		data = rsp_rdata;
		err = rsp_err;
	endtask

	task automatic read_check(input string name, input wbuf_pkg::addr_t addr,
			input wbuf_pkg::data_t expected);
		wbuf_pkg::data_t data;
		logic err;
		send_request(1'b0, addr, '0);
		wait_response(data, err);
		check_value({name, " data"}, expected, data);
		check_value({name, " err"}, 32'd0, 32'(err));
	endtask

	// every issued write has reached memory and the bus is quiet
	task automatic wait_drained();
		int cycles;
		cycles = 0;
		@(negedge clock);
		while (memory.log_addr.size() != exp_addr.size() || bus_request) begin
			cycles++;
			if (cycles > TIMEOUT) timeout_fail("the write buffer to drain");
			@(negedge clock);
		end
	endtask

	task automatic check_log(input string name);
		check_value({name, " log size"}, 32'(exp_addr.size()), 32'(memory.log_addr.size()));
		foreach (exp_addr[i]) begin
			check_value({name, " log addr"}, exp_addr[i], memory.log_addr[i]);
			check_value({name, " log data"}, exp_data[i], memory.log_data[i]);
		end
	endtask

	initial begin
		clock = 1'b0;
		rst_n = 1'b0;
		req_valid = 1'b0;
		req_rw = 1'b0;
		req_addr = '0;
		req_wdata = '0;
		stall = 1'b0;
		bus_starts = 0;
		bus_req_d = 1'b0;
		rng = 32'h666bcb97;
		repeat (5) @(posedge clock);
		rst_n <= 1'b1;

		@(negedge clock);
		check_value("reset ready", 32'd1, 32'(req_ready));
		check_value("reset bus request", 32'd0, 32'(bus_request));
		check_value("reset rsp valid", 32'd0, 32'(rsp_valid));

		read_check("read unwritten", 32'h0000_0100, ~32'h0000_0100);

		// read must wait behind the posted write
		wr_data = next_rand();
		send_request(1'b1, 32'h0000_0200, wr_data);
		read_check("read after write", 32'h0000_0200, wr_data);

		for (int i = 0; i < 6; i++) begin
			wr_addr = (i % 2 == 1) ? 32'h8000_0040 : 32'h0000_0040;	// odd ones uncached
			send_request(1'b1, wr_addr + 32'(i * 4), next_rand());
		end
		wait_drained();
		check_log("write order");

		// four fill the buffer and the fifth sits in the holding register
		@(posedge clock);
		stall <= 1'b1;
		for (int i = 0; i < 5; i++) begin
			send_request(1'b1, 32'h0000_0300 + 32'(i * 4), next_rand());
		end
		repeat (10) begin
			@(negedge clock);
			check_value("stalled ready", 32'd0, 32'(req_ready));
			check_value("stalled bus request", 32'd1, 32'(bus_request));
			check_value("stalled bus address", 32'h0000_0300, bus_address);
		end
		@(posedge clock);
		stall <= 1'b0;
		wait_drained();
		check_log("stall release");

		@(posedge clock);
		starts_before = bus_starts;
		begin
			wbuf_pkg::data_t data;
			logic err;
			send_request(1'b0, 32'h0000_0402, '0);
			wait_response(data, err);
			check_value("misaligned read err", 32'd1, 32'(err));
			send_request(1'b1, 32'h0000_0501, next_rand());
			wait_response(data, err);
			check_value("misaligned write err", 32'd1, 32'(err));
		end
		repeat (6) @(negedge clock);
		@(posedge clock);
		check_value("misaligned bus cycles", 32'(starts_before), 32'(bus_starts));
		check_log("misaligned");

		$display("Everything OK");
		$finish;
	end

endmodule

//--- src.f
+incdir+src
src/wbuf_pkg.sv
src/mem_req_if.sv
src/lsu_port.sv
src/write_buffer.sv
src/bus_master.sv
src/dcache_wb_top.sv
sim/bus_memory_model.sv
sim/tb_dcache_wb.sv

//--- src/bus_master.sv
`timescale 1ns/1ns

module bus_master (
	input  logic i_clock,
	input  logic i_rst_n,

	// from the write buffer
	mem_req_if.responder i_link,

	// external word bus
	output logic o_bus_request,
	output logic o_bus_rw,
	output wbuf_pkg::addr_t o_bus_address,
	output wbuf_pkg::data_t o_bus_wdata,
	input  logic i_bus_ready,
	input  wbuf_pkg::data_t i_bus_rdata
);

	wbuf_pkg::bus_state_e state;
	wbuf_pkg::data_t rdata_q;

	logic start;
	logic bus_done;

	assign start = (state == wbuf_pkg::BUS_IDLE) && i_link.valid;
	assign bus_done = (state == wbuf_pkg::BUS_WAIT) && i_bus_ready;

	// link completes one cycle after the bus did
	assign i_link.ready = (state == wbuf_pkg::BUS_DONE);
	assign i_link.rdata = rdata_q;

	always_ff @(posedge i_clock or negedge i_rst_n) begin
		if (!i_rst_n) begin
			state <= wbuf_pkg::BUS_IDLE;
			o_bus_request <= 1'b0;
			o_bus_rw <= 1'b0;
		end else begin
			case (state)
				wbuf_pkg::BUS_IDLE: begin
					if (i_link.valid) begin
						o_bus_request <= 1'b1;
						o_bus_rw <= i_link.rw;
						state <= wbuf_pkg::BUS_WAIT;
					end
				end
				wbuf_pkg::BUS_WAIT: begin
					if (i_bus_ready) begin
						o_bus_request <= 1'b0;	// held until now
						state <= wbuf_pkg::BUS_DONE;
					end
				end
				wbuf_pkg::BUS_DONE: begin
					state <= wbuf_pkg::BUS_IDLE;
				end
				default: begin
					state <= wbuf_pkg::BUS_IDLE;
				end
			endcase
		end
	end

	// address, data and read word
	always_ff @(posedge i_clock) begin
		if (start) begin
			o_bus_address <= i_link.addr;
			o_bus_wdata <= i_link.wdata;
		end
		if (bus_done) begin
			rdata_q <= i_bus_rdata;
		end
	end

endmodule

//--- src/dcache_wb_top.sv
`timescale 1ns/1ns

module dcache_wb_top (
	input  logic i_clock,
	input  logic i_rst_n,

	// core request
	input  logic i_req_valid,
	output logic o_req_ready,
	input  logic i_req_rw,
	input  wbuf_pkg::addr_t i_req_addr,
	input  wbuf_pkg::data_t i_req_wdata,

	// core response
	output logic o_rsp_valid,
	output wbuf_pkg::data_t o_rsp_rdata,
	output logic o_rsp_err,

	// external bus
	output logic o_bus_request,
	output logic o_bus_rw,
	output wbuf_pkg::addr_t o_bus_address,
	output wbuf_pkg::data_t o_bus_wdata,
	input  logic i_bus_ready,
	input  wbuf_pkg::data_t i_bus_rdata
);

	mem_req_if lsu_link ();
	mem_req_if bus_link ();

	logic cached;	// travels with lsu_link

	lsu_port u_lsu_port (
		.i_clock     (i_clock),
		.i_rst_n     (i_rst_n),
		.i_req_valid (i_req_valid),
		.o_req_ready (o_req_ready),
		.i_req_rw    (i_req_rw),
		.i_req_addr  (i_req_addr),
		.i_req_wdata (i_req_wdata),
		.o_rsp_valid (o_rsp_valid),
		.o_rsp_rdata (o_rsp_rdata),
		.o_rsp_err   (o_rsp_err),
		.o_link      (lsu_link.requester),
		.o_cached    (cached)
	);

	write_buffer u_write_buffer (
		.i_clock  (i_clock),
		.i_rst_n  (i_rst_n),
		.i_link   (lsu_link.responder),
		.i_cached (cached),
		.o_link   (bus_link.requester)
	);

	bus_master u_bus_master (
		.i_clock       (i_clock),
		.i_rst_n       (i_rst_n),
		.i_link        (bus_link.responder),
		.o_bus_request (o_bus_request),
		.o_bus_rw      (o_bus_rw),
		.o_bus_address (o_bus_address),
		.o_bus_wdata   (o_bus_wdata),
		.i_bus_ready   (i_bus_ready),
		.i_bus_rdata   (i_bus_rdata)
	);

endmodule

//--- src/lsu_port.sv
`timescale 1ns/1ns
`include "wbuf_macros.svh"

module lsu_port (
	input  logic i_clock,
	input  logic i_rst_n,

	// core request
	input  logic i_req_valid,
	output logic o_req_ready,
	input  logic i_req_rw,
	input  wbuf_pkg::addr_t i_req_addr,
	input  wbuf_pkg::data_t i_req_wdata,

	// core response
	output logic o_rsp_valid,
	output wbuf_pkg::data_t o_rsp_rdata,
	output logic o_rsp_err,

	// towards the write buffer
	mem_req_if.requester o_link,
	output logic o_cached
);

	logic hold_valid;
	logic hold_rw;
	wbuf_pkg::addr_t hold_addr;
	wbuf_pkg::data_t hold_wdata;

	logic capture;
	logic misaligned;
	logic link_done;

	assign o_req_ready = !hold_valid;	// single entry
	assign capture = i_req_valid && o_req_ready;
	assign misaligned = (i_req_addr[1:0] != 2'b00);
	assign link_done = hold_valid && o_link.ready;

	assign o_link.valid = hold_valid;
	assign o_link.rw = hold_rw;
	assign o_link.addr = hold_addr;
	assign o_link.wdata = hold_wdata;

	// region decode on the held address
	assign o_cached = !hold_addr[`WB_UNCACHED_BIT];

	always_ff @(posedge i_clock) begin
		if (capture) begin
			hold_rw <= i_req_rw;
			hold_addr <= i_req_addr;
			hold_wdata <= i_req_wdata;
		end
		if (link_done) begin
			o_rsp_rdata <= o_link.rdata;
		end else if (capture && misaligned) begin
			o_rsp_rdata <= '0;	// no data with an error
		end
	end

	always_ff @(posedge i_clock or negedge i_rst_n) begin
		if (!i_rst_n) begin
			hold_valid <= 1'b0;
			o_rsp_valid <= 1'b0;
			o_rsp_err <= 1'b0;
		end else begin
			o_rsp_valid <= 1'b0;	// one cycle pulse
			o_rsp_err <= 1'b0;

			// a bad address never reaches the link
			if (capture && misaligned) begin
				o_rsp_valid <= 1'b1;
				o_rsp_err <= 1'b1;
			end else if (capture) begin
				hold_valid <= 1'b1;
			end

			if (link_done) begin
				hold_valid <= 1'b0;
				o_rsp_valid <= !hold_rw;	// writes complete silently
			end
		end
	end

endmodule

//--- src/mem_req_if.sv
`timescale 1ns/1ns

// word request link between the memory path blocks
// valid and the fields stay put until ready, ready ends the transfer
interface mem_req_if;

	logic valid;
	logic ready;
	logic rw;		// 1 = write
	wbuf_pkg::addr_t addr;
	wbuf_pkg::data_t wdata;
	wbuf_pkg::data_t rdata;	// good in the ready cycle of a read

	modport requester (
		output valid,
		output rw,
		output addr,
		output wdata,
		input  ready,
		input  rdata
	);

	modport responder (
		input  valid,
		input  rw,
		input  addr,
		input  wdata,
		output ready,
		output rdata
	);

endinterface

//--- src/wbuf_macros.svh
`ifndef WBUF_MACROS_SVH
`define WBUF_MACROS_SVH

// bus widths
`define WB_ADDR_W 32
`define WB_DATA_W 32

// posted write slots, keep a power of two so ring pointers wrap on their own
`define WB_DEPTH 4

// top half of the address map is uncached I/O
`define WB_UNCACHED_BIT 31

`endif

//--- src/wbuf_pkg.sv
`include "wbuf_macros.svh"

package wbuf_pkg;

	// word address on the core side and on the bus
	typedef logic [`WB_ADDR_W-1:0] addr_t;

	// one data word
	typedef logic [`WB_DATA_W-1:0] data_t;

	// head/tail pointer into the write buffer ring
	typedef logic [$clog2(`WB_DEPTH)-1:0] slot_idx_t;

	// bus master cycle states
	typedef enum logic [1:0] {
		BUS_IDLE,	// waiting for a link request
		BUS_WAIT,	// request out, waiting for ready
		BUS_DONE	// completing the link
	} bus_state_e;

endpackage

//--- src/write_buffer.sv
`timescale 1ns/1ns
`include "wbuf_macros.svh"

module write_buffer (
	input  logic i_clock,
	input  logic i_rst_n,

	// from the load/store port
	mem_req_if.responder i_link,
	input  logic i_cached,

	// towards the bus master
	mem_req_if.requester o_link
);

	localparam int CNT_W = $clog2(`WB_DEPTH) + 1;

	// posted writes, oldest at head
	wbuf_pkg::addr_t slot_addr [`WB_DEPTH];
	wbuf_pkg::data_t slot_data [`WB_DEPTH];

	wbuf_pkg::slot_idx_t head;
	wbuf_pkg::slot_idx_t tail;
	logic [CNT_W-1:0] count;

	logic empty;
	logic full;
	logic post_req;
	logic bypass_req;
	logic do_post;
	logic do_drain;

	assign empty = (count == '0);
	assign full = (count == CNT_W'(`WB_DEPTH));

	// only cacheable writes may be posted
	assign post_req = i_link.valid && i_link.rw && i_cached;

	// reads and uncached writes go straight through
	assign bypass_req = i_link.valid && !(i_link.rw && i_cached);

	assign do_post = post_req && !full;

	// ready on the bus side belongs to the head slot while anything is queued
	assign do_drain = !empty && o_link.ready;

	// read data only matters for a bypassed read
	assign i_link.rdata = o_link.rdata;

	always_comb begin
		o_link.valid = 1'b0;
		o_link.rw = 1'b1;
		o_link.addr = slot_addr[head];
		o_link.wdata = slot_data[head];

		if (!empty) begin
			o_link.valid = 1'b1;	// drain oldest first
		end else if (bypass_req) begin
			o_link.valid = 1'b1;
			o_link.rw = i_link.rw;
			o_link.addr = i_link.addr;
			o_link.wdata = i_link.wdata;
		end
	end

	// a bypass request stalls here until every older write has left
	always_comb begin
		i_link.ready = 1'b0;
		if (post_req) begin
			i_link.ready = !full;	// done as soon as it is queued
		end else if (bypass_req && empty) begin
			i_link.ready = o_link.ready;
		end
	end

	always_ff @(posedge i_clock) begin
		if (do_post) begin
			slot_addr[tail] <= i_link.addr;
			slot_data[tail] <= i_link.wdata;
		end
	end

	always_ff @(posedge i_clock or negedge i_rst_n) begin
		if (!i_rst_n) begin
			head <= '0;
			tail <= '0;
			count <= '0;
		end else begin
			// pointers wrap naturally since depth is a power of two
			if (do_post) begin
				tail <= tail + 1'b1;
			end
			if (do_drain) begin
				head <= head + 1'b1;
			end

			if (do_post && !do_drain) begin
				count <= count + 1'b1;
			end else if (do_drain && !do_post) begin
				count <= count - 1'b1;
			end
		end
	end

endmodule
